// File: io_subsys.f
rtl/io_pkg.sv
rtl/io_bridge.sv
rtl/io_resp_merge.sv
rtl/io_dev_regs.sv
rtl/io_dev_timer.sv
rtl/io_subsys.sv
test/io_subsys_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Verilates the io_subsys testbench, builds it and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module io_subsys_tb \
	-f io_subsys.f \
	-o io_subsys_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/io_subsys_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with failing status $status"
	exit $status
fi

echo "Simulation ended with status 0"
exit 0

// File: test/io_subsys_tb.sv
module io_subsys_tb;

	// Where a table entry takes its store data from
	typedef enum logic [1:0] {DAT_TABLE, DAT_RAND, DAT_CNT10} dat_src_e;
	// How the data of a response is judged
	typedef enum logic [1:0] {EXP_DATA, EXP_MODEL, EXP_INCR, EXP_NONE} exp_kind_e;

	typedef struct packed {
		io_pkg::io_cmd_e cmd;
		logic [31:0]     addr;
		logic [7:0]      sel;
		logic [63:0]     data;
		dat_src_e        dsrc;
		exp_kind_e       ekind;
		logic [63:0]     exp_dat;
		logic            exp_err;
		// Low means the next entry follows in the very next cycle
		logic            wait_resp;
		logic [7:0]      idle_after;
	} entry_t;

	logic                clk_i;
	logic                rst_i;
	io_pkg::io_req128_t  req;
	io_pkg::io_resp128_t resp;

	entry_t table_q[$];
	string  name_q[$];

	// Bookkeeping indexed by tid, which is the table index of the request
	io_pkg::io_resp128_t exp_by_tid [256];
	io_pkg::io_resp128_t got_by_tid [256];
	exp_kind_e           kind_by_tid [256];
	string               name_by_tid [256];
	bit                  got_vld [256];
	bit                  outstanding [256];
	int                  pending_q[$];

	// Reference copy of the scratch bank and the last counter value seen
	logic [63:0] model_regs [8];
	logic [63:0] last_count;
	logic [31:0] lfsr_state;

	io_subsys i_io_subsys (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.req_i  (req),
		.resp_o (resp)
	);

	always #10 clk_i = ~clk_i;

	// ==========================================================
	// Helpers
	// ==========================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	// Galois form of x^32 + x^22 + x^2 + x + 1 that shifts right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [63:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[62:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Timer registers sit 8 bytes apart inside the window
	function automatic logic [31:0] timer_adr(input io_pkg::timer_reg_e r);
		timer_adr = io_pkg::TIMER_BASE + {26'd0, r, 3'b000};
	endfunction

	function automatic logic [31:0] regs_adr(input int idx);
		regs_adr = io_pkg::REGS_BASE + 32'(idx * 8);
	endfunction

	task automatic add_entry(input string name, input io_pkg::io_cmd_e cmd,
			input logic [31:0] addr, input logic [63:0] data, input dat_src_e dsrc,
			input exp_kind_e ekind, input logic [63:0] exp_dat, input logic exp_err,
			input logic wait_resp, input logic [7:0] idle_after);
		entry_t e;
		e = '{cmd, addr, 8'hFF, data, dsrc, ekind, exp_dat, exp_err, wait_resp, idle_after};
		table_q.push_back(e);
		name_q.push_back(name);
	endtask

	// ==========================================================
	// Compare tasks
	// ==========================================================

	task automatic check_err(input string name, input logic exp_err,
			input io_pkg::io_resp128_t act);
		if (act.err !== exp_err)
			abort_run($sformatf("Mismatch in %s: expected err %0b, actual err %0b",
				name, exp_err, act.err));
	endtask

	task automatic check_resp128(input string name, input io_pkg::io_resp128_t exp,
			input io_pkg::io_resp128_t act, input bit check_dat);
		string msg;
		if (act.ack !== exp.ack || act.tid !== exp.tid || act.adr !== exp.adr ||
				(check_dat && act.dat !== exp.dat)) begin
			msg = $sformatf("Mismatch in %s: expected ack %0b tid %0d adr %h dat %h",
				name, exp.ack, exp.tid, exp.adr, exp.dat);
			msg = {msg, $sformatf(", actual ack %0b tid %0d adr %h dat %h",
				act.ack, act.tid, act.adr, act.dat)};
			abort_run(msg);
		end
	endtask

	// Counter reads must climb and still show the same word in both halves
	task automatic check_count_rise(input string name, input logic [63:0] prev,
			input io_pkg::io_resp128_t act);
		if (act.dat[127:64] !== act.dat[63:0] || act.dat[63:0] <= prev)
			abort_run($sformatf("Mismatch in %s: expected count above %h, actual %h",
				name, prev, act.dat));
	endtask

	// ==========================================================
	// Request and response handling
	// ==========================================================

	// Responses are sampled on the rising edge one full cycle after they appear
	always @(posedge clk_i) begin
		if (!rst_i && (resp.ack || resp.err)) begin
			if (!outstanding[resp.tid])
				abort_run($sformatf("A response with tid %0d came back with no request open",
					resp.tid));
			else begin
				got_by_tid[resp.tid] = resp;
				got_vld[resp.tid] = 1'b1;
			end
		end
	end

	task automatic issue_entry(input int idx);
		entry_t              e;
		logic [63:0]         dat;
		logic [63:0]         rnd;
		io_pkg::io_resp128_t exp;
		e = table_q[idx];
		dat = e.data;
		if (e.dsrc == DAT_RAND) begin
			take_bits(64, dat);
			take_bits(8, rnd);
			e.sel = rnd[7:0];
		end else if (e.dsrc == DAT_CNT10) begin
			dat = last_count + 64'd10;
		end
		// Register stores land in the model one byte lane at a time
		if (e.cmd == io_pkg::IO_CMD_STORE &&
				(e.addr & io_pkg::REGS_MASK) == io_pkg::REGS_BASE) begin
			for (int b = 0; b < 8; b++)
				if (e.sel[b])
					model_regs[e.addr[5:3]][b*8 +: 8] = dat[b*8 +: 8];
		end
		exp = '0;
		exp.ack = !e.exp_err;
		exp.err = e.exp_err;
		exp.tid = 8'(idx);
		exp.adr = e.addr;
		if (e.ekind == EXP_DATA)
			exp.dat = {2{e.exp_dat}};
		else if (e.ekind == EXP_MODEL)
			exp.dat = {2{model_regs[e.addr[5:3]]}};
		exp_by_tid[idx] = exp;
		kind_by_tid[idx] = e.ekind;
		name_by_tid[idx] = name_q[idx];
		outstanding[idx] = 1'b1;
		pending_q.push_back(idx);
		@(negedge clk_i);
		// Upper lane holds junk that the bridge must drop
		req.cyc = 1'b1;
		req.cmd = e.cmd;
		req.sel = {8'hFF, e.sel};
		req.padr = e.addr;
		req.data1 = {~dat, dat};
		req.tid = 8'(idx);
	endtask

	task automatic wait_for_tid(input int tid);
		int cycles;
		cycles = 0;
		while (!got_vld[tid]) begin
			if (cycles == 200)
				abort_run($sformatf("No response for %s within 200 cycles", name_by_tid[tid]));
			else begin
				@(negedge clk_i);
				cycles++;
			end
		end
	endtask

	task automatic settle_pending();
		int                  tid;
		io_pkg::io_resp128_t act;
		while (pending_q.size() > 0) begin
			tid = pending_q.pop_front();
			wait_for_tid(tid);
			act = got_by_tid[tid];
			got_vld[tid] = 1'b0;
			outstanding[tid] = 1'b0;
			check_err(name_by_tid[tid], exp_by_tid[tid].err, act);
			check_resp128(name_by_tid[tid], exp_by_tid[tid], act,
				kind_by_tid[tid] inside {EXP_DATA, EXP_MODEL});
			if (kind_by_tid[tid] == EXP_INCR) begin
				check_count_rise(name_by_tid[tid], last_count, act);
				last_count = act.dat[63:0];
			end
		end
	endtask

	// ==========================================================
	// Stimulus table
	// ==========================================================

	task automatic build_table();
		// Two rounds of random partial stores mix the byte lanes before the read back
		for (int r = 0; r < 16; r++)
			add_entry($sformatf("reg_store_%0d", r), io_pkg::IO_CMD_STORE, regs_adr(r % 8),
				'0, DAT_RAND, EXP_NONE, '0, 1'b0, 1'b1, 8'd0);
		for (int r = 0; r < 8; r++)
			add_entry($sformatf("reg_load_%0d", r), io_pkg::IO_CMD_LOAD, regs_adr(r),
				'0, DAT_TABLE, EXP_MODEL, '0, 1'b0, 1'b1, 8'd0);
		add_entry("cmp_reset", io_pkg::IO_CMD_LOAD, timer_adr(io_pkg::TMR_COMPARE),
			'0, DAT_TABLE, EXP_DATA, '1, 1'b0, 1'b1, 8'd0);
		add_entry("cmp_store", io_pkg::IO_CMD_STORE, timer_adr(io_pkg::TMR_COMPARE),
			64'h0123_4567_89AB_CDEF, DAT_TABLE, EXP_NONE, '0, 1'b0, 1'b1, 8'd0);
		add_entry("cmp_load", io_pkg::IO_CMD_LOAD, timer_adr(io_pkg::TMR_COMPARE),
			'0, DAT_TABLE, EXP_DATA, 64'h0123_4567_89AB_CDEF, 1'b0, 1'b1, 8'd0);
		// The timer answer is one cycle slower, so both reach the merger together
		add_entry("col_timer", io_pkg::IO_CMD_LOAD, timer_adr(io_pkg::TMR_COMPARE),
			'0, DAT_TABLE, EXP_DATA, 64'h0123_4567_89AB_CDEF, 1'b0, 1'b0, 8'd0);
		add_entry("col_regs", io_pkg::IO_CMD_LOAD, regs_adr(5),
			'0, DAT_TABLE, EXP_MODEL, '0, 1'b0, 1'b1, 8'd0);
		add_entry("cnt_store", io_pkg::IO_CMD_STORE, timer_adr(io_pkg::TMR_COUNT),
			64'd5, DAT_TABLE, EXP_NONE, '0, 1'b1, 1'b1, 8'd0);
		add_entry("stat_store", io_pkg::IO_CMD_STORE, timer_adr(io_pkg::TMR_STATUS),
			'0, DAT_TABLE, EXP_NONE, '0, 1'b0, 1'b1, 8'd0);
		add_entry("cnt_load_a", io_pkg::IO_CMD_LOAD, timer_adr(io_pkg::TMR_COUNT),
			'0, DAT_TABLE, EXP_INCR, '0, 1'b0, 1'b1, 8'd0);
		add_entry("cnt_load_b", io_pkg::IO_CMD_LOAD, timer_adr(io_pkg::TMR_COUNT),
			'0, DAT_TABLE, EXP_INCR, '0, 1'b0, 1'b1, 8'd0);
		// Compare lands a few cycles ahead of the counter, then time passes it
		add_entry("cmp_cnt10", io_pkg::IO_CMD_STORE, timer_adr(io_pkg::TMR_COMPARE),
			'0, DAT_CNT10, EXP_NONE, '0, 1'b0, 1'b1, 8'd50);
		add_entry("stat_set", io_pkg::IO_CMD_LOAD, timer_adr(io_pkg::TMR_STATUS),
			'0, DAT_TABLE, EXP_DATA, 64'd1, 1'b0, 1'b1, 8'd0);
		add_entry("stat_clear", io_pkg::IO_CMD_STORE, timer_adr(io_pkg::TMR_STATUS),
			'0, DAT_TABLE, EXP_NONE, '0, 1'b0, 1'b1, 8'd0);
		add_entry("stat_zero", io_pkg::IO_CMD_LOAD, timer_adr(io_pkg::TMR_STATUS),
			'0, DAT_TABLE, EXP_DATA, 64'd0, 1'b0, 1'b1, 8'd0);
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================

	initial begin
		clk_i = 1'b0;
		rst_i = 1'b1;
		req = '0;
		lfsr_state = 32'h382d_1bc7;
		last_count = '0;
		for (int r = 0; r < 8; r++)
			model_regs[r] = '0;
		build_table();
		repeat (10) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		for (int i = 0; i < table_q.size(); i++) begin
			issue_entry(i);
			if (table_q[i].wait_resp) begin
				@(negedge clk_i);
				req = '0;
				settle_pending();
				repeat (table_q[i].idle_after) @(negedge clk_i);
			end
		end
		@(negedge clk_i);
		req = '0;
		settle_pending();
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: rtl/io_subsys.sv
module io_subsys (
	input  logic                 clk_i,
	input  logic                 rst_i,
	// CPU side port
	input  io_pkg::io_req128_t   req_i,
	output io_pkg::io_resp128_t  resp_o
);

	// Narrowed request broadcast to every device
	io_pkg::io_req64_t m_req;

	// Per device responses and the merged stream
	io_pkg::io_resp64_t [io_pkg::CHANNELS-1:0] dev_resp;
	io_pkg::io_resp64_t                        merged_resp;

	// Register stage between the CPU and the device bus
	io_bridge i_io_bridge (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.req_i    (req_i),
		.resp_o   (resp_o),
		.m_req_o  (m_req),
		.m_resp_i (merged_resp)
	);

	// Scratch registers sit on the priority channel
	io_dev_regs i_io_dev_regs (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.req_i  (m_req),
		.resp_o (dev_resp[io_pkg::CH_REGS])
	);

	io_dev_timer i_io_dev_timer (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.req_i  (m_req),
		.resp_o (dev_resp[io_pkg::CH_TIMER])
	);

	// Collapses the device channels into one response per cycle
	io_resp_merge i_io_resp_merge (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.resp_i (dev_resp),
		.resp_o (merged_resp)
	);

endmodule

// File: rtl/io_dev_timer.sv
module io_dev_timer (
	input  logic               clk_i,
	input  logic               rst_i,
	input  io_pkg::io_req64_t  req_i,
	output io_pkg::io_resp64_t resp_o
);

	// Timer state
	logic [63:0] count_q;
	logic [63:0] compare_q;
	logic        match_q;

	// Decoded request
	logic               hit;
	logic               is_load;
	logic               is_store;
	io_pkg::timer_reg_e reg_sel;

	// Next response fields and write strobes
	logic        ack_d;
	logic        err_d;
	logic [63:0] rd_dat;
	logic        wr_compare;
	logic        clr_match;

	// First response pipeline stage
	io_pkg::io_resp64_t s1_q;

	// ==========================================================
	// Decode
	// ==========================================================

	assign hit = req_i.cyc && ((req_i.padr & io_pkg::TIMER_MASK) == io_pkg::TIMER_BASE);
	assign is_load = hit && (req_i.cmd == io_pkg::IO_CMD_LOAD);
	assign is_store = hit && (req_i.cmd == io_pkg::IO_CMD_STORE);
	assign reg_sel = io_pkg::timer_reg_e'(req_i.padr[5:3]);

	// Unused offsets inside the window give no response at all
	always_comb begin
		ack_d = 1'b0;
		err_d = 1'b0;
		rd_dat = '0;
		wr_compare = 1'b0;
		clr_match = 1'b0;
		case (reg_sel)
			io_pkg::TMR_COUNT: begin
				// The counter is read only, so a store is refused
				ack_d = is_load;
				err_d = is_store;
				rd_dat = count_q;
			end
			io_pkg::TMR_COMPARE: begin
				ack_d = is_load || is_store;
				rd_dat = compare_q;
				wr_compare = is_store;
			end
			io_pkg::TMR_STATUS: begin
				ack_d = is_load || is_store;
				rd_dat = {63'd0, match_q};
				clr_match = is_store;
			end
			default: ;
		endcase
	end

	// ==========================================================
	// Counter, compare and match flag
	// ==========================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count_q <= '0;
			compare_q <= '1;
			match_q <= 1'b0;
		end else begin
			count_q <= count_q + 64'd1;
			// Compare stores take the full word, sel is not looked at
			if (wr_compare)
				compare_q <= req_i.dat;
			// A clear from software wins over a match in the same cycle
			if (clr_match)
				match_q <= 1'b0;
			else if (count_q == compare_q)
				match_q <= 1'b1;
		end
	end

	// ==========================================================
	// Two stage response pipeline
	// ==========================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			s1_q <= '0;
			resp_o <= '0;
		end else begin
			s1_q.ack <= ack_d;
			s1_q.err <= err_d;
			s1_q.dat <= ack_d ? rd_dat : 64'd0;
			s1_q.tid <= req_i.tid;
			s1_q.adr <= req_i.padr;
			// Second stage, so a new request can enter behind the first
			resp_o <= s1_q;
		end
	end

endmodule

// File: rtl/io_dev_regs.sv
module io_dev_regs (
	input  logic               clk_i,
	input  logic               rst_i,
	input  io_pkg::io_req64_t  req_i,
	output io_pkg::io_resp64_t resp_o
);

	// Scratch register storage
	logic [63:0] regs_q [io_pkg::REG_COUNT];

	// Decoded request
	logic       hit;
	logic       is_load;
	logic       is_store;
	logic [2:0] reg_idx;

	// ==========================================================
	// Decode
	// ==========================================================

	// The bank answers only inside its own 64-byte window
	assign hit = req_i.cyc && ((req_i.padr & io_pkg::REGS_MASK) == io_pkg::REGS_BASE);
	assign is_load = hit && (req_i.cmd == io_pkg::IO_CMD_LOAD);
	assign is_store = hit && (req_i.cmd == io_pkg::IO_CMD_STORE);

	// Registers are 64 bits wide, so address bits 5 to 3 pick one of eight
	assign reg_idx = req_i.padr[5:3];

	// ==========================================================
	// Register bank
	// ==========================================================

	// Stores update only the byte lanes enabled by sel
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int r = 0; r < io_pkg::REG_COUNT; r++)
				regs_q[r] <= '0;
		end else if (is_store) begin
			for (int b = 0; b < 8; b++) begin
				if (req_i.sel[b])
					regs_q[reg_idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
			end
		end
	end

	// ==========================================================
	// Response
	// ==========================================================

	// One cycle response, loads see the value before any store this cycle
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			resp_o <= '0;
		end else begin
			resp_o.ack <= is_load || is_store;
			// This device has no error cases
			resp_o.err <= 1'b0;
			resp_o.dat <= is_load ? regs_q[reg_idx] : 64'd0;
			resp_o.tid <= req_i.tid;
			resp_o.adr <= req_i.padr;
		end
	end

endmodule

// File: rtl/io_resp_merge.sv
module io_resp_merge (
	input  logic                                        clk_i,
	input  logic                                        rst_i,
	// One response channel per device
	input  io_pkg::io_resp64_t [io_pkg::CHANNELS-1:0]   resp_i,
	// Single merged stream towards the bridge
	output io_pkg::io_resp64_t                          resp_o
);

	// Count of new responses arriving this cycle
	logic [$clog2(io_pkg::CHANNELS+1)-1:0] new_cnt;

	// Lowest numbered new response and the one that loses to it
	io_pkg::io_resp64_t first_resp;
	io_pkg::io_resp64_t second_resp;

	// One entry hold register for a response that lost arbitration
	io_pkg::io_resp64_t hold_q;
	logic               hold_vld;

	// ==========================================================
	// Channel scan
	// ==========================================================

	// Channels are scanned from zero upward so the register bank wins
	always_comb begin
		new_cnt = '0;
		first_resp = '0;
		second_resp = '0;
		for (int i = 0; i < io_pkg::CHANNELS; i++) begin
			if (resp_i[i].ack || resp_i[i].err) begin
				if (new_cnt == '0)
					first_resp = resp_i[i];
				else
					second_resp = resp_i[i];
				new_cnt = new_cnt + 1'b1;
			end
		end
	end

	// ==========================================================
	// Output and hold
	// ==========================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			resp_o <= '0;
			hold_vld <= 1'b0;
		end else if (hold_vld) begin
			// A held response always goes out ahead of new ones
			resp_o <= hold_q;
			// Any newcomer takes the freed slot, so hold stays full
			hold_vld <= (new_cnt != '0);
		end else if (new_cnt != '0) begin
			resp_o <= first_resp;
			// The loser of a collision waits one cycle in the hold register
			hold_vld <= (new_cnt > 1);
		end else begin
			// Nothing to send this cycle
			resp_o <= '0;
		end
	end

	// Capture the response that has to wait for the next cycle
	always_ff @(posedge clk_i) begin
		if (hold_vld)
			hold_q <= first_resp;
		else if (new_cnt > 1)
			hold_q <= second_resp;
	end

	// With one request per cycle on the device bus, a collision can only
	// happen while the hold register is empty
	a_no_collision_when_held : assert property (
		@(posedge clk_i) disable iff (rst_i)
		hold_vld |-> (new_cnt < 2)
	) else $error("io_resp_merge: collision while a response is held");

endmodule

// File: rtl/io_bridge.sv
module io_bridge (
	input  logic                 clk_i,
	input  logic                 rst_i,
	// CPU side port
	input  io_pkg::io_req128_t   req_i,
	output io_pkg::io_resp128_t  resp_o,
	// Device side port
	output io_pkg::io_req64_t    m_req_o,
	input  io_pkg::io_resp64_t   m_resp_i
);

	// ==========================================================
	// Request stage
	// ==========================================================

	// Every CPU request is registered once before it reaches the devices
	// Only the lower byte lane is passed on, the upper lane never reaches the bus
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			m_req_o <= '0;
			// Idle address points at no device window
			m_req_o.padr <= 32'hFFFF_FFFF;
		end else begin
			if (req_i.cyc) begin
				m_req_o.cyc <= 1'b1;
				m_req_o.cmd <= req_i.cmd;
				m_req_o.sel <= req_i.sel[7:0];
				m_req_o.padr <= req_i.padr;
				m_req_o.dat <= req_i.data1[63:0];
				m_req_o.tid <= req_i.tid;
			end else begin
				// Idle cycles present a quiet bus to the devices
				m_req_o.cyc <= 1'b0;
				m_req_o.cmd <= io_pkg::IO_CMD_NOP;
				m_req_o.sel <= '0;
				m_req_o.padr <= 32'hFFFF_FFFF;
				m_req_o.dat <= '0;
				// The tid is left as it was since nothing qualifies it
			end
		end
	end

	// ==========================================================
	// Response stage
	// ==========================================================

	// The merged device response is registered once more and widened
	// The 64-bit data is repeated so either CPU half sees the value
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			resp_o <= '0;
		end else begin
			resp_o.ack <= m_resp_i.ack;
			resp_o.err <= m_resp_i.err;
			resp_o.dat <= {2{m_resp_i.dat}};
			resp_o.tid <= m_resp_i.tid;
			resp_o.adr <= m_resp_i.adr;
		end
	end

	// A device answers either ack or err and the merger never mixes two
	// responses, so the CPU must never see both at once
	a_resp_ack_err_excl : assert property (
		@(posedge clk_i) disable iff (rst_i)
		!(resp_o.ack && resp_o.err)
	) else $error("io_bridge: ack and err both high on the CPU response");

endmodule

// File: rtl/io_pkg.sv
package io_pkg;

	// ==========================================================
	// Subsystem constants
	// ==========================================================

	// Number of device response channels feeding the merger
	localparam int CHANNELS = 2;

	// Channel slots on the merger input, lower index wins a collision
	localparam int CH_REGS = 0;
	localparam int CH_TIMER = 1;

	// Depth of the scratch register bank
	localparam int REG_COUNT = 8;

	// Register bank window covers 64 bytes
	localparam logic [31:0] REGS_BASE = 32'hFFDC_0000;
	localparam logic [31:0] REGS_MASK = 32'hFFFF_FFC0;

	// Timer window covers the next 64-byte block above the 256-byte boundary
	localparam logic [31:0] TIMER_BASE = 32'hFFDC_0100;
	localparam logic [31:0] TIMER_MASK = 32'hFFFF_FFC0;

	// ==========================================================
	// Encodings
	// ==========================================================

	// Bus command carried on every request
	typedef enum logic [1:0] {
		IO_CMD_NOP   = 2'd0,
		IO_CMD_LOAD  = 2'd1,
		IO_CMD_STORE = 2'd2
	} io_cmd_e;

	// Timer register select taken from address bits 5 to 3
	// Byte offsets are 0, 8 and 16, so the encoded values step by one
	typedef enum logic [2:0] {
		TMR_COUNT   = 3'd0,
		TMR_COMPARE = 3'd1,
		TMR_STATUS  = 3'd2
	} timer_reg_e;

	// ==========================================================
	// Bus structures
	// ==========================================================

	// CPU side request, one cycle strobe qualified by cyc
	typedef struct packed {
		logic          cyc;
		io_cmd_e       cmd;
		// One enable per byte lane of data1
		logic [15:0]   sel;
		logic [31:0]   padr;
		logic [127:0]  data1;
		// Transaction id, returned unchanged on the response
		logic [7:0]    tid;
	} io_req128_t;

	// Device side request after the bridge has narrowed it
	typedef struct packed {
		logic          cyc;
		io_cmd_e       cmd;
		logic [7:0]    sel;
		logic [31:0]   padr;
		logic [63:0]   dat;
		logic [7:0]    tid;
	} io_req64_t;

	// Device response, ack and err are single cycle pulses
	typedef struct packed {
		logic          ack;
		logic          err;
		logic [63:0]   dat;
		logic [7:0]    tid;
		// Address of the request this response answers
		logic [31:0]   adr;
	} io_resp64_t;

	// CPU side response, data is repeated in both halves
	typedef struct packed {
		logic          ack;
		logic          err;
		logic [127:0]  dat;
		logic [7:0]    tid;
		logic [31:0]   adr;
	} io_resp128_t;

endpackage
